/* Makefile */
# Verilator build for the hello pattern testbench

TOP = hello_tb

.PHONY: all lint sim clean

all: sim

# static checks over the whole file list
lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

# build and run; the verdict comes from the printed pass line
sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf obj_dir

/* flist.f */
+incdir+hdl
hdl/hello_pkg.sv
hdl/display_timing.sv
hdl/bitmap_painter.sv
hdl/tmds_encoder.sv
hdl/hello_top.sv
verif/hello_properties.sv
verif/hello_tb.sv

/* hdl/bitmap_painter.sv */
/* "HELLO WORLD" bitmap ROM, 64x scaled lookup, palette
   and blanking, registered 8-bit pixel with delayed syncs */

`timescale 1ns/1ns
`default_nettype none

`include "hello_config.svh"

module bitmap_painter import hello_pkg::*; (
    input  logic   clk_pix,
    input  logic   rst_n,
    input  coord_t sx,
    input  coord_t sy,
    input  sync_t  sync,
    output pixel_t pix     // one clock behind sx/sy/sync
);

    localparam logic [11:0] FG = `HELLO_FG_RGB;
    localparam logic [11:0] BG = `HELLO_BG_RGB;

    // bitmap rows, MSB is the leftmost cell
    function automatic logic [`HELLO_BMAP_W-1:0] bmap_row(input logic [3:0] r);
        case (r)
            4'd0:    return 20'b1010_1110_1000_1000_0110;  // H E L L O
            4'd1:    return 20'b1010_1000_1000_1000_1010;
            4'd2:    return 20'b1110_1100_1000_1000_1010;
            4'd3:    return 20'b1010_1000_1000_1000_1010;
            4'd4:    return 20'b1010_1110_1110_1110_1100;
            4'd5:    return 20'b0000_0000_0000_0000_0000;  // gap between words
            4'd6:    return 20'b1010_0110_1110_1000_1100;  // W O R L D
            4'd7:    return 20'b1010_1010_1010_1000_1010;
            4'd8:    return 20'b1010_1010_1100_1000_1010;
            4'd9:    return 20'b1110_1010_1010_1000_1010;
            4'd10:   return 20'b1110_1100_1010_1110_1110;
            default: return '0;
        endcase
    endfunction

    coord_t                  cx, cy;   // bitmap cell under the beam
    logic [`HELLO_BMAP_W-1:0] row;
    logic [4:0]              bit_sel;  // row bit for column cx
    logic                    in_bmap;
    logic                    lit;
    logic [11:0]             rgb12;    // 4 bits per channel

    always_comb begin
        cx      = sx >> `HELLO_SCALE_SHIFT;
        cy      = sy >> `HELLO_SCALE_SHIFT;
        row     = bmap_row(cy[3:0]);
        bit_sel = 5'(`HELLO_BMAP_W - 1) - cx[4:0];  // MSB first
        in_bmap = (cx < coord_t'(`HELLO_BMAP_W)) && (cy < coord_t'(`HELLO_BMAP_H));
        lit     = sync.de && in_bmap && row[bit_sel];
    end

    // yellow on blue in the active area, black in blanking
    always_comb begin
        if (!sync.de)
            rgb12 = 12'h000;
        else if (lit)
            rgb12 = FG;
        else
            rgb12 = BG;
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            pix <= '0;
        end else begin
            pix.sync  <= sync;                 // keep syncs aligned with colour
            pix.rgb.r <= {2{rgb12[11:8]}};     // 4 to 8 bits by repetition
            pix.rgb.g <= {2{rgb12[7:4]}};
            pix.rgb.b <= {2{rgb12[3:0]}};
        end
    end

endmodule

`default_nettype wire

/* hdl/display_timing.sv */
/* 720p raster generator: column and line counters
   with registered hsync, vsync and de */

`timescale 1ns/1ns
`default_nettype none

`include "hello_config.svh"

module display_timing import hello_pkg::*; (
    input  logic   clk_pix,
    input  logic   rst_n,
    output coord_t sx,     // current column
    output coord_t sy,     // current line
    output sync_t  sync    // syncs and de for (sx, sy)
);

    localparam coord_t H_LAST = coord_t'(`HELLO_H_ACTIVE + `HELLO_H_FP
                                         + `HELLO_H_SYNC + `HELLO_H_BP - 1);
    localparam coord_t V_LAST = coord_t'(`HELLO_V_ACTIVE + `HELLO_V_FP
                                         + `HELLO_V_SYNC + `HELLO_V_BP - 1);
    localparam coord_t HS_BEG = coord_t'(`HELLO_H_ACTIVE + `HELLO_H_FP);  // 1390
    localparam coord_t HS_END = coord_t'(`HELLO_H_ACTIVE + `HELLO_H_FP + `HELLO_H_SYNC);
    localparam coord_t VS_BEG = coord_t'(`HELLO_V_ACTIVE + `HELLO_V_FP);  // 725
    localparam coord_t VS_END = coord_t'(`HELLO_V_ACTIVE + `HELLO_V_FP + `HELLO_V_SYNC);
    localparam coord_t H_ACT  = coord_t'(`HELLO_H_ACTIVE);
    localparam coord_t V_ACT  = coord_t'(`HELLO_V_ACTIVE);

    logic   run;      // low until the first pixel has been presented
    coord_t nx, ny;   // next position
    sync_t  nsync;    // syncs decoded for the next position

    // next raster position, holds (0,0) on the first edge out of reset
    always_comb begin
        nx = sx;
        ny = sy;
        if (run) begin
            if (sx == H_LAST) begin
                nx = '0;
                ny = (sy == V_LAST) ? '0 : sy + 1'b1;  // wrap at end of frame
            end else begin
                nx = sx + 1'b1;
            end
        end
    end

    // decode windows from the next position so sync lands with its counters
    always_comb begin
        nsync.hsync = (nx >= HS_BEG) && (nx < HS_END);
        nsync.vsync = (ny >= VS_BEG) && (ny < VS_END);
        nsync.de    = (nx < H_ACT) && (ny < V_ACT);
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            run  <= 1'b0;
            sx   <= '0;
            sy   <= '0;
            sync <= '0;  // all blank until the raster starts
        end else begin
            run  <= 1'b1;
            sx   <= nx;
            sy   <= ny;
            sync <= nsync;
        end
    end

endmodule

`default_nettype wire

/* hdl/hello_config.svh */
/* 720p raster timing, bitmap geometry, scale shift
   and foreground/background palette for the hello pattern */

`ifndef HELLO_CONFIG_SVH
`define HELLO_CONFIG_SVH

// horizontal timing in pixels, total 1650
`define HELLO_H_ACTIVE 1280
`define HELLO_H_FP     110
`define HELLO_H_SYNC   40
`define HELLO_H_BP     220

// vertical timing in lines, total 750
`define HELLO_V_ACTIVE 720
`define HELLO_V_FP     5
`define HELLO_V_SYNC   5
`define HELLO_V_BP     20

`define HELLO_SCALE_SHIFT 6   // 64x scale, one bitmap cell per 64x64 block
`define HELLO_BMAP_W      20  // bitmap columns
`define HELLO_BMAP_H      11  // bitmap rows

`define HELLO_FG_RGB 12'hFC0  // yellow lines
`define HELLO_BG_RGB 12'h137  // blue background

`endif

/* hdl/hello_pkg.sv */
/* shared types: screen coordinate, sync bundle, pixel,
   TMDS symbol and bus, encoder mode */

`default_nettype none

package hello_pkg;

    typedef logic [11:0] coord_t;  // screen coordinate, covers 0..1649

    typedef struct packed {
        logic hsync;  // active high
        logic vsync;  // active high
        logic de;     // high in active area
    } sync_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb888_t;

    typedef struct packed {
        sync_t   sync;
        rgb888_t rgb;
    } pixel_t;

    typedef logic [9:0] tmds_sym_t;  // one 10-bit DVI symbol, bit 0 sent first

    typedef struct packed {
        tmds_sym_t ch2;  // red
        tmds_sym_t ch1;  // green
        tmds_sym_t ch0;  // blue plus syncs
    } tmds_bus_t;

    typedef enum logic {
        TMDS_CTRL,   // blanking, send control symbol
        TMDS_VIDEO   // active area, send data symbol
    } tmds_mode_e;

endpackage

`default_nettype wire

/* hdl/hello_top.sv */
/* hello pattern top: raster timing, bitmap painter
   and three TMDS encoders producing the symbol bundle */

`timescale 1ns/1ns
`default_nettype none

module hello_top import hello_pkg::*; (
    input  logic      clk_pix,
    input  logic      rst_n,
    output tmds_bus_t tmds     // three symbols per pixel clock
);

    coord_t    sx, sy;
    sync_t     sync;
    pixel_t    pix;
    tmds_sym_t sym_b, sym_g, sym_r;

    display_timing u_timing (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .sx      (sx),
        .sy      (sy),
        .sync    (sync)
    );

    bitmap_painter u_painter (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .sx      (sx),
        .sy      (sy),
        .sync    (sync),
        .pix     (pix)
    );

    // blue channel carries the syncs in blanking
    tmds_encoder u_enc_ch0 (.clk_pix(clk_pix), .rst_n(rst_n), .data(pix.rgb.b),
        .ctrl({pix.sync.vsync, pix.sync.hsync}), .de(pix.sync.de), .sym(sym_b));
    tmds_encoder u_enc_ch1 (.clk_pix(clk_pix), .rst_n(rst_n), .data(pix.rgb.g),
        .ctrl(2'b00), .de(pix.sync.de), .sym(sym_g));
    tmds_encoder u_enc_ch2 (.clk_pix(clk_pix), .rst_n(rst_n), .data(pix.rgb.r),
        .ctrl(2'b00), .de(pix.sync.de), .sym(sym_r));

    assign tmds.ch0 = sym_b;
    assign tmds.ch1 = sym_g;
    assign tmds.ch2 = sym_r;

endmodule

`default_nettype wire

/* hdl/tmds_encoder.sv */
/* DVI 8b/10b TMDS encoder: transition minimisation,
   running disparity and the four control symbols */

`timescale 1ns/1ns
`default_nettype none

module tmds_encoder import hello_pkg::*; (
    input  logic       clk_pix,
    input  logic       rst_n,
    input  logic [7:0] data,   // colour byte
    input  logic [1:0] ctrl,   // control bits sent in blanking
    input  logic       de,
    output tmds_sym_t  sym
);

    localparam tmds_sym_t CTRL_00 = 10'b1101010100;
    localparam tmds_sym_t CTRL_01 = 10'b0010101011;
    localparam tmds_sym_t CTRL_10 = 10'b0101010100;
    localparam tmds_sym_t CTRL_11 = 10'b1010101011;

    tmds_mode_e       mode;
    logic [3:0]       n1d;       // ones in data
    logic             use_xnor;
    logic [8:0]       q_m;       // transition minimised word, bit 8 marks xor
    logic [3:0]       n1q;       // ones in q_m[7:0]
    logic signed [5:0] bal;      // ones minus zeros of q_m[7:0]
    logic signed [5:0] disp;     // running disparity
    logic signed [5:0] disp_nx;
    tmds_sym_t        sym_nx;

    assign mode = de ? TMDS_VIDEO : TMDS_CTRL;

    // stage 1 of the DVI rule, pick xor or xnor chaining
    always_comb begin
        n1d = '0;
        for (int i = 0; i < 8; i++)
            n1d = n1d + 4'(data[i]);
        use_xnor = (n1d > 4'd4) || ((n1d == 4'd4) && !data[0]);
        q_m[0] = data[0];
        for (int i = 1; i < 8; i++)
            q_m[i] = use_xnor ? ~(q_m[i-1] ^ data[i]) : (q_m[i-1] ^ data[i]);
        q_m[8] = ~use_xnor;
        n1q = '0;
        for (int i = 0; i < 8; i++)
            n1q = n1q + 4'(q_m[i]);
        bal = $signed({1'b0, n1q, 1'b0}) - 6'sd8;  // 2*n1q - 8
    end

    // stage 2, dc balancing against the running disparity
    always_comb begin
        sym_nx  = CTRL_00;
        disp_nx = disp;
        case (mode)
            TMDS_CTRL: begin
                disp_nx = '0;  // disparity restarts after every blanking
                case (ctrl)
                    2'b00: sym_nx = CTRL_00;
                    2'b01: sym_nx = CTRL_01;
                    2'b10: sym_nx = CTRL_10;
                    default: sym_nx = CTRL_11;
                endcase
            end
            TMDS_VIDEO: begin
                if (disp == 6'sd0 || bal == 6'sd0) begin
                    sym_nx  = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
                    disp_nx = q_m[8] ? disp + bal : disp - bal;
                end else if ((disp > 6'sd0 && bal > 6'sd0) || (disp < 6'sd0 && bal < 6'sd0)) begin
                    sym_nx  = {1'b1, q_m[8], ~q_m[7:0]};  // invert to pull back
                    disp_nx = disp + (q_m[8] ? 6'sd2 : 6'sd0) - bal;
                end else begin
                    sym_nx  = {1'b0, q_m[8], q_m[7:0]};
                    disp_nx = disp - (q_m[8] ? 6'sd0 : 6'sd2) + bal;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            sym  <= CTRL_00;
            disp <= '0;
        end else begin
            sym  <= sym_nx;
            disp <= disp_nx;
        end
    end

endmodule

`default_nettype wire

/* verif/hello_properties.sv */
/* concurrent checks bound into the raster generator
   and the three TMDS encoders */

`timescale 1ns/1ns
`default_nettype none

`include "hello_config.svh"

module hello_properties import hello_pkg::*; (
    input logic              clk_pix,
    input logic              rst_n,
    input logic              hsync,   // tied low on encoders
    input logic              de,
    input tmds_sym_t         sym,     // tied to ctrl 00 on the timing block
    input logic signed [5:0] disp     // tied to zero on the timing block
);

    logic [7:0] hs_len;  // cycles hsync has been high so far

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            hs_len <= '0;
        end else if (hsync) begin
            hs_len <= hs_len + 1'b1;
        end else begin
            hs_len <= '0;
        end
    end

    // DVI balancing keeps the running count within one full byte swing
    disp_bound: assert property (@(posedge clk_pix) disable iff (!rst_n)
        (disp >= -6'sd8) && (disp <= 6'sd8))
        else $error("encoder running disparity %0d outside the +-8 bound", disp);

    // blanking input gives one of the four control tokens a clock later
    ctrl_legal: assert property (@(posedge clk_pix) disable iff (!rst_n)
        !de |=> (sym inside {10'b1101010100, 10'b0010101011,
                             10'b0101010100, 10'b1010101011}))
        else $error("illegal control symbol %b during blanking", sym);

    hsync_width: assert property (@(posedge clk_pix) disable iff (!rst_n)
        $fell(hsync) |-> (hs_len == 8'(`HELLO_H_SYNC)))
        else $error("hsync pulse lasted %0d cycles", hs_len);

endmodule

// encoder instances, no sync visible here
bind tmds_encoder hello_properties u_props (.clk_pix(clk_pix), .rst_n(rst_n),
    .hsync(1'b0), .de(de), .sym(sym), .disp(disp));

// raster generator, no symbol or disparity here
bind display_timing hello_properties u_props (.clk_pix(clk_pix), .rst_n(rst_n),
    .hsync(sync.hsync), .de(sync.de), .sym(10'b1101010100), .disp(6'sd0));

`default_nettype wire

/* verif/hello_tb.sv */
/* testbench for the hello pattern: clock and reset, probe table,
   TMDS decoder, raster model, checks and watchdog */

`timescale 1ns/1ns
`default_nettype none

`include "hello_config.svh"

module hello_tb import hello_pkg::*; ();

    localparam int H_TOTAL = `HELLO_H_ACTIVE + `HELLO_H_FP + `HELLO_H_SYNC + `HELLO_H_BP;
    localparam int V_TOTAL = `HELLO_V_ACTIVE + `HELLO_V_FP + `HELLO_V_SYNC + `HELLO_V_BP;
    localparam int FRAME   = H_TOTAL * V_TOTAL;  // cycles per frame
    localparam int LATENCY = 3;   // edges from reset release until position 0 shows
    localparam int N_RAND  = 32;
    localparam int SEG     = FRAME / N_RAND;     // one random probe per segment
    localparam longint WATCHDOG_NS = 64'(3 * FRAME) * 100 + 100_000;

    localparam logic [11:0] FG12 = `HELLO_FG_RGB;
    localparam logic [11:0] BG12 = `HELLO_BG_RGB;
    localparam rgb888_t FG8   = {{2{FG12[11:8]}}, {2{FG12[7:4]}}, {2{FG12[3:0]}}};
    localparam rgb888_t BG8   = {{2{BG12[11:8]}}, {2{BG12[7:4]}}, {2{BG12[3:0]}}};
    localparam rgb888_t BLACK = '0;

    localparam sync_t S_ACT   = '{hsync: 1'b0, vsync: 1'b0, de: 1'b1};
    localparam sync_t S_BLANK = '{hsync: 1'b0, vsync: 1'b0, de: 1'b0};
    localparam sync_t S_HSYNC = '{hsync: 1'b1, vsync: 1'b0, de: 1'b0};
    localparam sync_t S_VSYNC = '{hsync: 1'b0, vsync: 1'b1, de: 1'b0};

    typedef struct {
        string   name;
        int      x;
        int      y;
        sync_t   sync;  // expected syncs and de
        rgb888_t rgb;   // expected colour
    } probe_t;

    logic      clk_pix;
    logic      rst_n;
    tmds_bus_t tmds;
    int        edges;          // rising edges since reset release
    int        run_disp [3];   // ones minus zeros per channel since last control token
    int        err_sym;
    int        err_rgb;
    int        err_sync;
    int        err_other;
    probe_t    probes [7];

    // "HELLO" over "WORLD", one character per cell, X marks a lit cell
    string bitmap [`HELLO_BMAP_H] = '{
        "X.X.XXX.X...X....XX.",
        "X.X.X...X...X...X.X.",
        "XXX.XX..X...X...X.X.",
        "X.X.X...X...X...X.X.",
        "X.X.XXX.XXX.XXX.XX..",
        "....................",
        "X.X..XX.XXX.X...XX..",
        "X.X.X.X.X.X.X...X.X.",
        "X.X.X.X.XX..X...X.X.",
        "XXX.X.X.X.X.X...X.X.",
        "XXX.XX..X.X.XXX.XXX."
    };

    hello_top UUT (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .tmds    (tmds)
    );

    initial clk_pix = 1'b0;
    always #50 clk_pix = ~clk_pix;  // 100 ns period

    function automatic tmds_sym_t ctrl_token(input logic [1:0] c);
        case (c)
            2'b00:   return 10'b1101010100;
            2'b01:   return 10'b0010101011;
            2'b10:   return 10'b0101010100;
            default: return 10'b1010101011;
        endcase
    endfunction

    function automatic logic is_ctrl(input tmds_sym_t s);
        for (int k = 0; k < 4; k++)
            if (s == ctrl_token(2'(k)))
                return 1'b1;
        return 1'b0;
    endfunction

    function automatic logic [1:0] ctrl_bits(input tmds_sym_t s);
        for (int k = 0; k < 4; k++)
            if (s == ctrl_token(2'(k)))
                return 2'(k);
        return 2'b00;
    endfunction

    // bit 9 undoes the inversion, bit 8 says xor (1) or xnor (0) chaining
    function automatic logic [7:0] decode_data(input tmds_sym_t s);
        logic [7:0] q;
        logic [7:0] d;
        q    = s[9] ? ~s[7:0] : s[7:0];
        d[0] = q[0];
        for (int i = 1; i < 8; i++)
            d[i] = s[8] ? (q[i] ^ q[i-1]) : ~(q[i] ^ q[i-1]);
        return d;
    endfunction

    function automatic int ones_minus_zeros(input tmds_sym_t s);
        int n;
        n = 0;
        for (int i = 0; i < 10; i++)
            n += s[i] ? 1 : -1;
        return n;
    endfunction

    function automatic int raster_index(input int x, input int y, input int frame);
        return frame * FRAME + y * H_TOTAL + x;
    endfunction

    // reference model of one raster position
    function automatic void predict(input int x, input int y,
                                    output sync_t s, output rgb888_t c);
        int   cx;
        int   cy;
        logic lit;
        cx      = x >> `HELLO_SCALE_SHIFT;
        cy      = y >> `HELLO_SCALE_SHIFT;
        s.hsync = (x >= `HELLO_H_ACTIVE + `HELLO_H_FP)
                  && (x < `HELLO_H_ACTIVE + `HELLO_H_FP + `HELLO_H_SYNC);
        s.vsync = (y >= `HELLO_V_ACTIVE + `HELLO_V_FP)
                  && (y < `HELLO_V_ACTIVE + `HELLO_V_FP + `HELLO_V_SYNC);
        s.de    = (x < `HELLO_H_ACTIVE) && (y < `HELLO_V_ACTIVE);
        lit     = 1'b0;
        if (s.de && cx < `HELLO_BMAP_W && cy < `HELLO_BMAP_H)
            lit = (bitmap[cy].getc(cx) == "X");
        if (!s.de)
            c = BLACK;
        else if (lit)
            c = FG8;
        else
            c = BG8;
    endfunction

    // blue channel carries de and the syncs
    function automatic void decode_pixel(input tmds_bus_t t,
                                         output sync_t s, output rgb888_t c);
        if (is_ctrl(t.ch0)) begin
            s.de                = 1'b0;
            {s.vsync, s.hsync}  = ctrl_bits(t.ch0);
            c                   = BLACK;
        end else begin
            s = S_ACT;
            c = {decode_data(t.ch2), decode_data(t.ch1), decode_data(t.ch0)};
        end
    endfunction

    task automatic check_sym(input string name, input tmds_sym_t exp, input tmds_sym_t act);
        if (act !== exp) begin
            $display("mismatch %s: expected %b actual %b", name, exp, act);
            err_sym++;
        end
    endtask

    task automatic check_rgb(input string name, input rgb888_t exp, input rgb888_t act);
        if (act !== exp) begin
            $display("mismatch %s: expected rgb %h actual rgb %h", name, exp, act);
            err_rgb++;
        end
    endtask

    task automatic check_sync(input string name, input sync_t exp, input sync_t act);
        if (act !== exp) begin
            $display("mismatch %s: expected hsync,vsync,de %b%b%b actual %b%b%b", name,
                     exp.hsync, exp.vsync, exp.de, act.hsync, act.vsync, act.de);
            err_sync++;
        end
    endtask

    // one clock, sampled 1 ns after the edge, with the disparity bound checked
    task automatic advance_clock();
        tmds_sym_t s [3];
        @(posedge clk_pix);
        #1;
        edges++;
        s[0] = tmds.ch0;
        s[1] = tmds.ch1;
        s[2] = tmds.ch2;
        for (int ch = 0; ch < 3; ch++) begin
            if (is_ctrl(s[ch]))
                run_disp[ch] = 0;  // blanking restarts the count
            else
                run_disp[ch] += ones_minus_zeros(s[ch]);
            if (run_disp[ch] > 8 || run_disp[ch] < -8) begin
                $display("channel %0d running disparity %0d is out of bounds at edge %0d",
                         ch, run_disp[ch], edges);
                err_other++;
            end
        end
    endtask

    task automatic wait_position(input string name, input int target);
        if (edges - LATENCY > target) begin
            $display("probe %s at position %0d was already passed", name, target);
            err_other++;
        end
        while (edges - LATENCY < target)
            advance_clock();
    endtask

    task automatic probe(input string name, input int x, input int y, input int frame,
                         input sync_t exp_sync, input rgb888_t exp_rgb);
        sync_t   act_sync;
        rgb888_t act_rgb;
        wait_position(name, raster_index(x, y, frame));
        decode_pixel(tmds, act_sync, act_rgb);
        check_sync(name, exp_sync, act_sync);
        check_rgb(name, exp_rgb, act_rgb);
        if (!exp_sync.de) begin
            check_sym(name, ctrl_token({exp_sync.vsync, exp_sync.hsync}), tmds.ch0);
            check_sym(name, ctrl_token(2'b00), tmds.ch1);
            check_sym(name, ctrl_token(2'b00), tmds.ch2);
        end
    endtask

    initial begin
        int      off;
        sync_t   exp_sync;
        rgb888_t exp_rgb;
        rst_n     = 1'b0;
        edges     = 0;
        err_sym   = 0;
        err_rgb   = 0;
        err_sync  = 0;
        err_other = 0;
        run_disp  = '{0, 0, 0};
        void'($urandom(32'h1f354bf4));
        // fixed probes in raster order, all in the first frame
        probes[0] = '{"h_of_hello",   0,    0,   S_ACT,   FG8};
        probes[1] = '{"gap",          192,  0,   S_ACT,   BG8};
        probes[2] = '{"hblank",       1300, 10,  S_BLANK, BLACK};
        probes[3] = '{"hsync",        1400, 10,  S_HSYNC, BLACK};
        probes[4] = '{"row5_blank",   64,   320, S_ACT,   BG8};
        probes[5] = '{"outside_bmap", 1279, 719, S_ACT,   BG8};
        probes[6] = '{"vsync",        10,   726, S_VSYNC, BLACK};
        repeat (16) @(posedge clk_pix);
        #1 rst_n = 1'b1;
        // pipeline still holds reset values until position 0 arrives
        for (int k = 0; k < LATENCY; k++) begin
            if (k > 0)
                advance_clock();
            check_sym("reset_ctrl_ch0", ctrl_token(2'b00), tmds.ch0);
            check_sym("reset_ctrl_ch1", ctrl_token(2'b00), tmds.ch1);
            check_sym("reset_ctrl_ch2", ctrl_token(2'b00), tmds.ch2);
        end
        foreach (probes[i])
            probe(probes[i].name, probes[i].x, probes[i].y, 0, probes[i].sync, probes[i].rgb);
        // second frame, one random position per segment keeps them in order
        for (int i = 0; i < N_RAND; i++) begin
            off = i * SEG + int'($urandom % 32'(SEG));
            predict(off % H_TOTAL, off / H_TOTAL, exp_sync, exp_rgb);
            probe($sformatf("random_%0d", i), off % H_TOTAL, off / H_TOTAL, 1,
                  exp_sync, exp_rgb);
        end
        $display("errors: sym %0d rgb %0d sync %0d other %0d",
                 err_sym, err_rgb, err_sync, err_other);
        if (err_sym + err_rgb + err_sync + err_other == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // three frames of pixel clocks plus reset and margin
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns before all probes were reached", WATCHDOG_NS);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire
